// ==== flist.f ====
+incdir+.
cpuPkg.sv
regFile.sv
executeUnit.sv
controlUnit.sv
cpuCore.sv
tbCpu.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CPU testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tbCpu -f flist.f || exit 1
out=$(./obj_dir/VtbCpu)
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED" && exit 0 || exit 1

// ==== tbCpu.sv ====
`include "cpu_params.svh"

module tbCpu;
  timeunit 1ns;
  timeprecision 1ps;
  import cpuPkg::*;

  localparam int WaitLimit = 100;

  logic                   clk;
  logic                   rstN;
  logic [`DATA_W-1:0]     instr;
  logic                   instrValid;
  logic                   wbReady;
  logic                   instrReady;
  logic                   wbValid;
  logic                   wbWrite;
  logic [`REG_ADDR_W-1:0] wbReg;
  logic [`DATA_W-1:0]     wbData;
  flags_t                 flags;

  // Reference state
  logic [`DATA_W-1:0] mRegs [`REG_COUNT];
  flags_t             mFlags;

  int checkCount;
  int errorCount;
  int testCount;
  int failedTests;

  cpuCore u_dut (
    .clk        (clk),
    .rstN       (rstN),
    .instr      (instr),
    .instrValid (instrValid),
    .wbReady    (wbReady),
    .instrReady (instrReady),
    .wbValid    (wbValid),
    .wbWrite    (wbWrite),
    .wbReg      (wbReg),
    .wbData     (wbData),
    .flags      (flags)
  );

  always #20 clk = ~clk;

  task automatic checkData(input string name, input logic [`DATA_W-1:0] got,
                           input logic [`DATA_W-1:0] exp);
    checkCount++;
    if (got !== exp)
    begin
      errorCount++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkReg(input string name, input logic [`REG_ADDR_W-1:0] got,
                          input logic [`REG_ADDR_W-1:0] exp);
    checkCount++;
    if (got !== exp)
    begin
      errorCount++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    checkCount++;
    if (got !== exp)
    begin
      errorCount++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkFlags(input string name, input flags_t got, input flags_t exp);
    checkCount++;
    if (got !== exp)
    begin
      errorCount++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic abortRun(input string why);
    $display("ERROR: %s", why);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  function automatic logic [3:0] rand4();
    return 4'($urandom_range(0, 15));
  endfunction

  function automatic logic [11:0] rand12();
    return 12'($urandom_range(0, 4095));
  endfunction

  // Bits 31:26 are don't-care and get random filler
  function automatic logic [`DATA_W-1:0] makeInstr(input logic iBit, input logic [3:0] opc,
                                                   input logic sBit, input logic [3:0] rn,
                                                   input logic [3:0] rd, input logic [11:0] op2);
    logic [5:0] pad;
    pad = 6'($urandom_range(0, 63));
    return {pad, iBit, opc, sBit, rn, rd, op2};
  endfunction

  // Reference result for one instruction, using current model state
  task automatic modelExec(input logic [`DATA_W-1:0] ins, output logic [`DATA_W-1:0] res,
                           output logic wr, output flags_t nf);
    aluOp_e             opc;
    logic [`DATA_W-1:0] a;
    logic [`DATA_W-1:0] b;
    logic [`DATA_W-1:0] x;
    logic [`DATA_W-1:0] y;
    longint             ua;
    longint             ub;
    longint             sa;
    longint             sb;
    longint             ci;
    longint             cAdd;
    longint             bw;
    longint             us;
    longint             ss;
    logic               arith;
    logic               isSub;
    logic               isCmp;
    int                 amt;
    opc   = aluOp_e'(ins[24:21]);
    a     = mRegs[ins[19:16]];
    arith = 1'b0;
    if (ins[25])
    begin
      b   = {24'd0, ins[7:0]};
      amt = 2 * int'(ins[11:8]);
      repeat (amt) b = {b[0], b[31:1]};
    end
    else
    begin
      b = mRegs[ins[3:0]];
    end
    ci  = mFlags.c ? 1 : 0;
    res = '0;
    case (opc)
      AND, TST: res = a & b;
      EOR, TEQ: res = a ^ b;
      ORR:      res = a | b;
      MOV:      res = b;
      BIC:      res = a & ~b;
      MVN:      res = ~b;
      default:  arith = 1'b1;
    endcase
    // Reverse subtractions take B first
    isSub = opc inside {SUB, SBC, RSB, RSC, CMP};
    x     = (opc inside {RSB, RSC}) ? b : a;
    y     = (opc inside {RSB, RSC}) ? a : b;
    cAdd  = (opc == ADC) ? ci : 0;
    bw    = (opc inside {SBC, RSC}) ? 1 - ci : 0;
    ua    = {32'd0, x};
    ub    = {32'd0, y};
    sa    = $signed(x);
    sb    = $signed(y);
    if (isSub)
    begin
      us = ua - ub - bw;
      ss = sa - sb - bw;
    end
    else
    begin
      us = ua + ub + cAdd;
      ss = sa + sb + cAdd;
    end
    if (arith)
    begin
      res = us[31:0];
    end
    isCmp = (opc == TST) || (opc == TEQ) || (opc == CMP) || (opc == CMN);
    wr    = !isCmp;
    nf    = mFlags;
    if (isCmp || ins[20])
    begin
      nf.n = res[31];
      nf.z = (res == '0);
      if (arith)
      begin
        // Carry on subtraction means no borrow
        nf.c = isSub ? !us[63] : us[32];
        nf.v = (ss[63:31] != {33{ss[31]}});
      end
      else
      begin
        nf.v = 1'b0;
      end
    end
  endtask

  // Runs one instruction through both handshakes, starting and ending on a falling edge
  task automatic runInstr(input logic [`DATA_W-1:0] ins, input int gap, input int hold);
    logic [`DATA_W-1:0] expData;
    logic               expWrite;
    flags_t             expFlags;
    int                 waitCount;
    modelExec(ins, expData, expWrite, expFlags);
    repeat (gap) @(negedge clk);
    waitCount = 0;
    while (!instrReady && waitCount < WaitLimit)
    begin
      @(negedge clk);
      waitCount++;
    end
    if (!instrReady)
      abortRun("instrReady never went high");
    instr      = ins;
    instrValid = 1'b1;
    wbReady    = 1'b0;
    @(posedge clk);
    @(negedge clk);
    instrValid = 1'b0;
    instr      = $urandom;
    waitCount  = 0;
    while (!wbValid && waitCount < WaitLimit)
    begin
      @(negedge clk);
      waitCount++;
    end
    if (!wbValid)
      abortRun("wbValid never went high after an accepted instruction");
    checkCount++;
    if (waitCount != 1)
    begin
      errorCount++;
      $display("ERROR: wbValid rose %0d cycles after accept instead of 1", waitCount);
    end
    checkData("wbData", wbData, expData);
    checkBit("wbWrite", wbWrite, expWrite);
    checkReg("wbReg", wbReg, ins[15:12]);
    checkFlags("flags", flags, expFlags);
    if (expWrite)
      mRegs[ins[15:12]] = expData;
    mFlags = expFlags;
    for (int k = 0; k < hold; k++)
    begin
      @(negedge clk);
      checkBit("wbValid", wbValid, 1'b1);
      checkBit("instrReady", instrReady, 1'b0);
      checkData("wbData", wbData, expData);
      checkBit("wbWrite", wbWrite, expWrite);
      checkReg("wbReg", wbReg, ins[15:12]);
      checkFlags("flags", flags, expFlags);
    end
    wbReady = 1'b1;
    @(posedge clk);
    @(negedge clk);
    wbReady = 1'b0;
    checkBit("wbValid", wbValid, 1'b0);
    checkBit("instrReady", instrReady, 1'b1);
  endtask

  // Builds a full 32-bit value in a register from four rotated bytes
  task automatic loadReg(input logic [3:0] r, input logic [`DATA_W-1:0] value);
    runInstr(makeInstr(1'b1, MOV, 1'b0, 4'd0, r, {4'd0, value[7:0]}), 0, 0);
    runInstr(makeInstr(1'b1, ORR, 1'b0, r, r, {4'd12, value[15:8]}), 0, 0);
    runInstr(makeInstr(1'b1, ORR, 1'b0, r, r, {4'd8, value[23:16]}), 0, 0);
    runInstr(makeInstr(1'b1, ORR, 1'b0, r, r, {4'd4, value[31:24]}), 0, 0);
  endtask

  task automatic finishTest(input string name, input int errorsBefore);
    testCount++;
    if (errorCount != errorsBefore)
    begin
      failedTests++;
      $display("test %0d %s: %0d errors", testCount, name, errorCount - errorsBefore);
    end
    else
    begin
      $display("test %0d %s: ok", testCount, name);
    end
  endtask

  initial
  begin
    aluOp_e arithOps [6];
    logic [3:0] opc;
    logic [3:0] rd;
    int errorsBefore;
    clk         = 1'b0;
    rstN        = 1'b0;
    instr       = '0;
    instrValid  = 1'b0;
    wbReady     = 1'b0;
    checkCount  = 0;
    errorCount  = 0;
    testCount   = 0;
    failedTests = 0;
    arithOps    = '{ADD, ADC, SUB, SBC, RSB, RSC};
    void'($urandom(32'h7db5_6064));
    for (int i = 0; i < `REG_COUNT; i++)
      mRegs[i] = '0;
    mFlags = '0;
    repeat (10) @(negedge clk);
    rstN = 1'b1;
    @(negedge clk);

    errorsBefore = errorCount;
    checkBit("instrReady", instrReady, 1'b1);
    checkBit("wbValid", wbValid, 1'b0);
    checkBit("wbWrite", wbWrite, 1'b0);
    checkFlags("flags", flags, '0);
    for (int r = 0; r < `REG_COUNT; r++)
      runInstr(makeInstr(1'b0, MOV, 1'b0, 4'd0, 4'(r), {8'd0, 4'(r)}), 0, 0);
    finishTest("reset state", errorsBefore);

    errorsBefore = errorCount;
    for (int n = 0; n < 40; n++)
    begin
      opc = ($urandom_range(0, 1) == 0) ? MOV : MVN;
      runInstr(makeInstr(1'b1, opc, 1'($urandom_range(0, 1)), rand4(), rand4(), rand12()),
               0, 0);
    end
    finishTest("immediate path", errorsBefore);

    errorsBefore = errorCount;
    for (int r = 0; r < `REG_COUNT; r++)
      loadReg(4'(r), $urandom);
    for (int n = 0; n < 60; n++)
    begin
      opc = arithOps[$urandom_range(0, 5)];
      runInstr(makeInstr(1'b0, opc, 1'($urandom_range(0, 1)), rand4(), rand4(), rand12()),
               0, 0);
    end
    finishTest("arithmetic and flags", errorsBefore);

    errorsBefore = errorCount;
    for (int n = 0; n < 40; n++)
    begin
      opc = 4'(8 + $urandom_range(0, 3));
      rd  = rand4();
      runInstr(makeInstr(1'($urandom_range(0, 1)), opc, 1'($urandom_range(0, 1)), rand4(),
                         rd, rand12()), 0, 0);
      runInstr(makeInstr(1'b0, MOV, 1'b0, 4'd0, rd, {8'd0, rd}), 0, 0);
    end
    finishTest("compare and test", errorsBefore);

    errorsBefore = errorCount;
    for (int n = 0; n < 30; n++)
    begin
      runInstr(makeInstr(1'($urandom_range(0, 1)), rand4(), 1'($urandom_range(0, 1)), rand4(),
                         rand4(), rand12()), 0, $urandom_range(1, 8));
    end
    finishTest("latency and back-pressure", errorsBefore);

    errorsBefore = errorCount;
    for (int n = 0; n < 400; n++)
    begin
      runInstr(makeInstr(1'($urandom_range(0, 1)), rand4(), 1'($urandom_range(0, 1)), rand4(),
                         rand4(), rand12()), $urandom_range(0, 2), $urandom_range(0, 3));
    end
    finishTest("random mix", errorsBefore);

    $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
             testCount, failedTests, checkCount, errorCount);
    if (errorCount == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== cpuCore.sv ====
`include "cpu_params.svh"

module cpuCore (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [`DATA_W-1:0]     instr,
  input  logic                   instrValid,
  input  logic                   wbReady,
  output logic                   instrReady,
  output logic                   wbValid,
  output logic                   wbWrite,
  output logic [`REG_ADDR_W-1:0] wbReg,
  output logic [`DATA_W-1:0]     wbData,
  output cpuPkg::flags_t         flags
);
  import cpuPkg::*;

  logic [`REG_ADDR_W-1:0] rdAddrA;
  logic [`REG_ADDR_W-1:0] rdAddrB;
  logic [`REG_ADDR_W-1:0] wrAddr;
  logic                   wrEn;
  logic                   useImm;
  logic                   flagEn;
  logic [`ROT_W-1:0]      immRot;
  logic [`IMM_W-1:0]      imm8;
  aluOp_e                 op;
  logic [`DATA_W-1:0]     rdDataA;
  logic [`DATA_W-1:0]     rdDataB;
  logic [`DATA_W-1:0]     aluResult;

  controlUnit u_control (
    .clk        (clk),
    .rstN       (rstN),
    .instr      (instr),
    .instrValid (instrValid),
    .instrReady (instrReady),
    .wbValid    (wbValid),
    .wbReady    (wbReady),
    .wbWrite    (wbWrite),
    .wbReg      (wbReg),
    .wbData     (wbData),
    .aluResult  (aluResult),
    .rdAddrA    (rdAddrA),
    .rdAddrB    (rdAddrB),
    .wrAddr     (wrAddr),
    .wrEn       (wrEn),
    .useImm     (useImm),
    .flagEn     (flagEn),
    .immRot     (immRot),
    .imm8       (imm8),
    .op         (op)
  );

  regFile u_regFile (
    .clk     (clk),
    .rstN    (rstN),
    .rdAddrA (rdAddrA),
    .rdAddrB (rdAddrB),
    .wrAddr  (wrAddr),
    .wrEn    (wrEn),
    .wrData  (aluResult),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB)
  );

  executeUnit u_execute (
    .clk    (clk),
    .rstN   (rstN),
    .opA    (rdDataA),
    .regB   (rdDataB),
    .useImm (useImm),
    .flagEn (flagEn),
    .immRot (immRot),
    .imm8   (imm8),
    .op     (op),
    .result (aluResult),
    .flags  (flags)
  );

endmodule

// ==== controlUnit.sv ====
`include "cpu_params.svh"

module controlUnit (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [`DATA_W-1:0]     instr,
  input  logic                   instrValid,
  output logic                   instrReady,
  output logic                   wbValid,
  input  logic                   wbReady,
  output logic                   wbWrite,
  output logic [`REG_ADDR_W-1:0] wbReg,
  output logic [`DATA_W-1:0]     wbData,
  input  logic [`DATA_W-1:0]     aluResult,
  output logic [`REG_ADDR_W-1:0] rdAddrA,
  output logic [`REG_ADDR_W-1:0] rdAddrB,
  output logic [`REG_ADDR_W-1:0] wrAddr,
  output logic                   wrEn,
  output logic                   useImm,
  output logic                   flagEn,
  output logic [`ROT_W-1:0]      immRot,
  output logic [`IMM_W-1:0]      imm8,
  output cpuPkg::aluOp_e         op
);
  import cpuPkg::*;

  ctrlState_e         state;
  ctrlState_e         stateNext;
  logic [`DATA_W-1:0] instrQ;
  logic               sBit;
  logic               isCompare;

  always_comb
  begin
    case (state)
      IDLE:    stateNext = instrValid ? EXECUTE : IDLE;
      EXECUTE: stateNext = RESULT;
      RESULT:  stateNext = wbReady ? IDLE : RESULT;
      default: stateNext = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state <= IDLE;
    end
    else
    begin
      state <= stateNext;
    end
  end

  always_ff @(posedge clk)
  begin
    if (instrValid && instrReady)
    begin
      instrQ <= instr;
    end
  end

  // Result captured on the same edge as the register write
  always_ff @(posedge clk)
  begin
    if (state == EXECUTE)
    begin
      wbData <= aluResult;
    end
  end

  // Field decode from the held instruction
  assign op        = aluOp_e'(instrQ[24:21]);
  assign sBit      = instrQ[20];
  assign useImm    = instrQ[25];
  assign rdAddrA   = instrQ[19:16];
  assign wrAddr    = instrQ[15:12];
  assign immRot    = instrQ[11:8];
  assign imm8      = instrQ[7:0];
  assign rdAddrB   = instrQ[3:0];
  assign isCompare = op inside {TST, TEQ, CMP, CMN};

  // Compares never write but always set flags
  assign wrEn   = (state == EXECUTE) && !isCompare;
  assign flagEn = (state == EXECUTE) && (sBit || isCompare);

  assign instrReady = (state == IDLE);
  assign wbValid    = (state == RESULT);
  assign wbWrite    = wbValid && !isCompare;
  assign wbReg      = instrQ[15:12];

  assert property (@(posedge clk) disable iff (!rstN)
    !(instrReady && wbValid));

  // Result must hold until taken
  assert property (@(posedge clk) disable iff (!rstN)
    wbValid && !wbReady |=> wbValid && $stable(wbData));

endmodule

// ==== executeUnit.sv ====
`include "cpu_params.svh"

module executeUnit (
  input  logic               clk,
  input  logic               rstN,
  input  logic [`DATA_W-1:0] opA,
  input  logic [`DATA_W-1:0] regB,
  input  logic               useImm,
  input  logic               flagEn,
  input  logic [`ROT_W-1:0]  immRot,
  input  logic [`IMM_W-1:0]  imm8,
  input  cpuPkg::aluOp_e     op,
  output logic [`DATA_W-1:0] result,
  output cpuPkg::flags_t     flags
);
  import cpuPkg::*;

  logic [`DATA_W-1:0]   immExt;
  logic [2*`DATA_W-1:0] immPair;
  logic [`DATA_W-1:0]   opB;
  logic [`DATA_W-1:0]   addX;
  logic [`DATA_W-1:0]   addY;
  logic                 addCin;
  logic [`DATA_W:0]     addSum;
  logic                 addV;
  logic                 isArith;
  flags_t               flagQ;
  flags_t               flagD;

  // imm8 rotated right by twice the rotate field
  assign immExt  = {{(`DATA_W-`IMM_W){1'b0}}, imm8};
  assign immPair = {immExt, immExt} >> {immRot, 1'b0};
  assign opB     = useImm ? immPair[`DATA_W-1:0] : regB;

  // One adder for all arithmetic, subtraction adds the inverted operand
  always_comb
  begin
    addX    = opA;
    addY    = opB;
    addCin  = 1'b0;
    isArith = 1'b0;
    case (op)
      ADD, CMN:
      begin
        isArith = 1'b1;
      end
      ADC:
      begin
        isArith = 1'b1;
        addCin  = flagQ.c;
      end
      SUB, CMP:
      begin
        isArith = 1'b1;
        addY    = ~opB;
        addCin  = 1'b1;
      end
      SBC:
      begin
        isArith = 1'b1;
        addY    = ~opB;
        addCin  = flagQ.c;
      end
      RSB:
      begin
        isArith = 1'b1;
        addX    = opB;
        addY    = ~opA;
        addCin  = 1'b1;
      end
      RSC:
      begin
        isArith = 1'b1;
        addX    = opB;
        addY    = ~opA;
        addCin  = flagQ.c;
      end
      default:
      begin
        isArith = 1'b0;
      end
    endcase
  end

  assign addSum = {1'b0, addX} + {1'b0, addY} + {{`DATA_W{1'b0}}, addCin};
  // Overflow when both addends agree in sign and the sum does not
  assign addV   = (addX[`DATA_W-1] == addY[`DATA_W-1]) &&
                  (addSum[`DATA_W-1] != addX[`DATA_W-1]);

  always_comb
  begin
    case (op)
      AND, TST: result = opA & opB;
      EOR, TEQ: result = opA ^ opB;
      ORR:      result = opA | opB;
      MOV:      result = opB;
      BIC:      result = opA & ~opB;
      MVN:      result = ~opB;
      default:  result = addSum[`DATA_W-1:0];
    endcase
  end

  // Logical ops keep C and clear V
  assign flagD.n = result[`DATA_W-1];
  assign flagD.z = (result == '0);
  assign flagD.c = isArith ? addSum[`DATA_W] : flagQ.c;
  assign flagD.v = isArith ? addV : 1'b0;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      flagQ <= '0;
    end
    else if (flagEn)
    begin
      flagQ <= flagD;
    end
  end

  assign flags = flagQ;

endmodule

// ==== regFile.sv ====
`include "cpu_params.svh"

module regFile (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [`REG_ADDR_W-1:0] rdAddrA,
  input  logic [`REG_ADDR_W-1:0] rdAddrB,
  input  logic [`REG_ADDR_W-1:0] wrAddr,
  input  logic                   wrEn,
  input  logic [`DATA_W-1:0]     wrData,
  output logic [`DATA_W-1:0]     rdDataA,
  output logic [`DATA_W-1:0]     rdDataB
);

  logic [`DATA_W-1:0] regs [`REG_COUNT];

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < `REG_COUNT; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wrEn)
    begin
      regs[wrAddr] <= wrData;
    end
  end

  // Reads are combinational, a write shows up after the edge
  assign rdDataA = regs[rdAddrA];
  assign rdDataB = regs[rdAddrB];

  assert property (@(posedge clk) disable iff (!rstN)
    wrEn |-> !$isunknown(wrAddr));

endmodule

// ==== cpuPkg.sv ====
package cpuPkg;

  // Opcode field of a data-processing instruction
  typedef enum logic [3:0] {
    AND = 4'd0,
    EOR = 4'd1,
    SUB = 4'd2,
    RSB = 4'd3,
    ADD = 4'd4,
    ADC = 4'd5,
    SBC = 4'd6,
    RSC = 4'd7,
    TST = 4'd8,
    TEQ = 4'd9,
    CMP = 4'd10,
    CMN = 4'd11,
    ORR = 4'd12,
    MOV = 4'd13,
    BIC = 4'd14,
    MVN = 4'd15
  } aluOp_e;

  typedef enum logic [1:0] {
    IDLE,
    EXECUTE,
    RESULT
  } ctrlState_e;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

endpackage

// ==== cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Data path and instruction width
`define DATA_W 32

// Register file
`define REG_COUNT 16
`define REG_ADDR_W 4

// Immediate operand fields
`define IMM_W 8
`define ROT_W 4

`endif
